// ==== Makefile ====
VERILATOR ?= verilator
TOP       := cart_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# The simulator exits non-zero on any $fatal or failed assertion
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/cart_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module cart_sva (
    input wire                     sys_clk,
    input wire                     pll_lock,
    input wire                     rw,
    input wire                     phi2,
    input wire                     halt,
    input wire                     sd_rd,
    input wire                     sd_byte_valid,
    input wire                     d_drive,
    input cart_pkg::loader_state_e state
);

    // Sector request is a single-cycle pulse
    sd_rd_pulse: assert property (@(posedge sys_clk) disable iff (!pll_lock)
        sd_rd |=> !sd_rd)
        else $error("sd_rd stayed high for two cycles");

    // Pad driver only for a bus read in the drive window two edges earlier
    drive_follows_bus: assert property (@(posedge sys_clk) disable iff (!pll_lock)
        d_drive |-> $past(rw, 2) &&
                    (($past(phi2, 2) && $past(halt, 2)) || !$past(halt, 2)))
        else $error("d_drive high without a bus read in the drive window");

    no_strobe_in_idle: assert property (@(posedge sys_clk) disable iff (!pll_lock)
        sd_byte_valid |-> (state != cart_pkg::LD_IDLE))
        else $error("sd_byte_valid seen while the loader is idle");

endmodule

bind cart_top cart_sva u_sva (
    .sys_clk       (sys_clk),
    .pll_lock      (pll_lock),
    .rw            (rw),
    .phi2          (phi2),
    .halt          (halt),
    .sd_rd         (sd_rd),
    .sd_byte_valid (sd_byte_valid),
    .d_drive       (d_drive),
    .state         (u_loader.state)
);

`default_nettype wire

// ==== bench/cart_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cart_macros.svh"

module cart_tb;

    localparam int SECTOR_LEN  = int'(`SECTOR_BYTES);
    localparam int HEADER_LEN  = int'(`HEADER_BYTES);
    localparam int NUM_SECTORS = int'(`IMAGE_SECTORS);
    localparam int CAPACITY    = int'(`CART_BYTES);
    localparam int IMAGE_LEN   = SECTOR_LEN * NUM_SECTORS;  // 49664 bytes

    logic                 sys_clk;
    logic                 pll_lock;
    cart_pkg::bus_addr_t  a;
    logic                 rw;
    logic                 phi2;
    logic                 halt;
    cart_pkg::data_byte_t d_in;
    cart_pkg::data_byte_t d_out;
    logic                 d_drive;
    logic                 buf_dir;
    logic                 buf_oe;
    logic                 sd_ready;
    logic                 sd_rd;
    cart_pkg::sector_t    sd_sector;
    cart_pkg::data_byte_t sd_byte;
    logic                 sd_byte_valid;

    cart_pkg::data_byte_t image [0:IMAGE_LEN-1];  // Sector source contents
    cart_pkg::checksum_t  model_sum;

    cart_top u_dut (
        .sys_clk       (sys_clk),
        .pll_lock      (pll_lock),
        .a             (a),
        .rw            (rw),
        .phi2          (phi2),
        .halt          (halt),
        .d_in          (d_in),
        .d_out         (d_out),
        .d_drive       (d_drive),
        .buf_dir       (buf_dir),
        .buf_oe        (buf_oe),
        .sd_ready      (sd_ready),
        .sd_rd         (sd_rd),
        .sd_sector     (sd_sector),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid)
    );

    always #50 sys_clk = ~sys_clk;

    // ======================================================================
    // Reporting and timing helpers
    // ======================================================================
    task automatic stop_with_failure(input string why);
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
            stop_with_failure("a checked value was wrong");
        end
    endtask

    task automatic step_cycle();
        @(posedge sys_clk);
        #1;  // Drive and sample away from the edge
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    task automatic fill_image();
        model_sum = '0;
        for (int i = 0; i < IMAGE_LEN; i++) begin
            image[i] = 8'($urandom);
        end
        // Stored payload skips the header and stops at capacity
        for (int o = 0; o < CAPACITY; o++) begin
            model_sum = model_sum + 32'(image[HEADER_LEN + o]);
        end
    endtask

    function automatic cart_pkg::data_byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + 8'(nib);
        end
        return 8'h41 + 8'(nib) - 8'd10;
    endfunction

    // ======================================================================
    // Sector source
    // ======================================================================
    task automatic wait_sd_rd();
        int n;
        n = 0;
        while (!sd_rd) begin
            if (n == 64) begin
                stop_with_failure("Timed out waiting for a sector request on sd_rd");
            end
            step_cycle();
            n++;
        end
    endtask

    task automatic serve_image();
        for (int s = 0; s < NUM_SECTORS; s++) begin
            wait_sd_rd();
            check_value("sd_sector", 32'(sd_sector), 32'(s));
            for (int i = 0; i < SECTOR_LEN; i++) begin
                sd_byte       = image[s * SECTOR_LEN + i];
                sd_byte_valid = 1'b1;
                step_cycle();
                sd_byte_valid = 1'b0;
                if (i != SECTOR_LEN - 1) begin
                    repeat (1 + ($urandom % 3)) step_cycle();  // Random gap
                end
            end
        end
    endtask

    // ======================================================================
    // Bus tasks
    // ======================================================================
    task automatic read_bus(input cart_pkg::bus_addr_t addr, input logic p2,
                            input logic hl, output cart_pkg::data_byte_t data,
                            output logic drv);
        a    = addr;
        rw   = 1'b1;
        phi2 = p2;
        halt = hl;
        repeat (4) step_cycle();
        data = d_out;
        drv  = d_drive;
    endtask

    task automatic bus_write(input cart_pkg::bus_addr_t addr,
                             input cart_pkg::data_byte_t data);
        a    = addr;
        rw   = 1'b0;
        phi2 = 1'b1;
        halt = 1'b1;
        d_in = data;
        repeat (4) step_cycle();
        check_value("buf_dir", 32'(buf_dir), 32'd0);
        check_value("d_drive", 32'(d_drive), 32'd0);
        check_value("buf_oe", 32'(buf_oe), 32'(addr != `STATUS_ADDR));
        rw   = 1'b1;
        phi2 = 1'b0;
        a    = 16'h0000;
        repeat (2) step_cycle();
    endtask

    task automatic check_read(input cart_pkg::bus_addr_t addr, input logic p2,
                              input logic hl, input logic drv_exp,
                              input cart_pkg::data_byte_t data_exp);
        cart_pkg::data_byte_t data;
        logic                 drv;
        read_bus(addr, p2, hl, data, drv);
        check_value("d_drive", 32'(drv), 32'(drv_exp));
        check_value("buf_oe", 32'(buf_oe), 32'(!drv_exp));
        check_value("buf_dir", 32'(buf_dir), 32'd1);
        if (drv_exp) begin
            check_value("d_out", 32'(data), 32'(data_exp));
        end
    endtask

    task automatic wait_ready();
        cart_pkg::data_byte_t data;
        logic                 drv;
        int                   n;
        n    = 0;
        data = `STATUS_BUSY;
        while (data != `STATUS_READY) begin
            if (n == 16) begin
                stop_with_failure("Timed out waiting for the status byte to read ready");
            end
            read_bus(`STATUS_ADDR, 1'b1, 1'b1, data, drv);
            n++;
        end
        check_read(`STATUS_ADDR, 1'b1, 1'b1, 1'b1, `STATUS_READY);
    endtask

    // "CRC: " then eight hex digits, then spaces
    task automatic check_crc_text();
        logic [39:0]          prefix;
        cart_pkg::data_byte_t expc;
        prefix = "CRC: ";
        for (int p = 0; p < 16; p++) begin
            if (p < 5) begin
                expc = prefix[8 * (4 - p) +: 8];
            end else if (p < 13) begin
                expc = hex_char(model_sum[4 * (12 - p) +: 4]);
            end else begin
                expc = 8'h20;
            end
            check_read(16'(int'(`CRC_WIN_BASE) + p), 1'b1, 1'b1, 1'b1, expc);
        end
    endtask

    task automatic check_menu_decode();
        cart_pkg::bus_addr_t addr;
        for (int k = 0; k < 8; k++) begin
            addr = 16'(int'(`CART_BASE) + int'($urandom % CAPACITY));
            if (addr >= `CRC_WIN_BASE && addr <= `CRC_WIN_LAST) begin
                addr = addr + 16'h0020;  // Step out of the text window
            end
            check_read(addr, 1'b1, 1'b1, 1'b1, `BLANK_BYTE);
            addr = 16'($urandom % 16384);
            if (addr == `STATUS_ADDR) begin
                addr = addr + 16'h0001;
            end
            check_read(addr, 1'b1, 1'b1, 1'b0, `BLANK_BYTE);
        end
        check_read(`STATUS_ADDR, 1'b0, 1'b1, 1'b0, `STATUS_READY);
        check_read(`STATUS_ADDR, 1'b0, 1'b0, 1'b1, `STATUS_READY);  // DMA window
        check_read(16'h9000, 1'b0, 1'b0, 1'b1, `BLANK_BYTE);
    endtask

    task automatic check_game_mode();
        int unsigned off;
        bus_write(`STATUS_ADDR, 8'h80);
        for (int k = 0; k < 16; k++) begin
            off = $urandom % CAPACITY;
            check_read(16'(int'(`CART_BASE) + int'(off)), 1'b1, 1'b1, 1'b1,
                       image[HEADER_LEN + int'(off)]);
            if (k % 4 == 0) begin
                bus_write(16'(int'(`CART_BASE) + int'($urandom % CAPACITY)), 8'($urandom));
            end
        end
        check_read(`STATUS_ADDR, 1'b1, 1'b1, 1'b0, `STATUS_READY);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        sys_clk       = 1'b0;
        pll_lock      = 1'b0;
        a             = '0;
        rw            = 1'b1;
        phi2          = 1'b0;
        halt          = 1'b1;
        d_in          = '0;
        sd_ready      = 1'b0;
        sd_byte       = '0;
        sd_byte_valid = 1'b0;
        void'($urandom(80));
        fill_image();

        repeat (16) @(posedge sys_clk);
        #1 pll_lock = 1'b1;
        check_value("d_out", 32'(d_out), 32'(`BLANK_BYTE));
        check_value("buf_oe", 32'(buf_oe), 32'd1);

        sd_ready = 1'b1;  // First load starts from idle
        fork
            serve_image();
            repeat (3) check_read(`STATUS_ADDR, 1'b1, 1'b1, 1'b1, `STATUS_BUSY);
        join
        wait_ready();
        check_crc_text();
        check_menu_decode();

        // Reload from a fresh image
        fill_image();
        fork
            serve_image();
            begin
                bus_write(`STATUS_ADDR, 8'h40);
                repeat (3) check_read(`STATUS_ADDR, 1'b1, 1'b1, 1'b1, `STATUS_BUSY);
            end
        join
        wait_ready();
        check_crc_text();

        check_game_mode();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/cart_pkg.sv
verilog/bus_decode.sv
verilog/image_loader.sv
verilog/cart_ram.sv
verilog/read_mux.sv
verilog/cart_top.sv
bench/cart_sva.sv
bench/cart_tb.sv

// ==== verilog/bus_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cart_macros.svh"

module bus_decode (
    input  wire                  sys_clk,
    input  wire                  pll_lock,
    input  cart_pkg::bus_addr_t  a,
    input  wire                  rw,
    input  wire                  phi2,
    input  wire                  halt,
    input  cart_pkg::data_byte_t d_in,
    input  wire                  game_mode,
    output cart_pkg::read_src_e  read_src,
    output logic [3:0]           crc_pos,
    output cart_pkg::cart_index_t cart_rd_index,
    output logic                 ctrl_write,
    output cart_pkg::data_byte_t ctrl_data,
    output logic                 d_drive,
    output logic                 buf_dir,
    output logic                 buf_oe
);

    // ======================================================================
    // Input synchronizer
    // ======================================================================
    cart_pkg::bus_addr_t  a_sync;
    cart_pkg::data_byte_t d_sync;
    logic                 rw_sync;
    logic                 phi2_sync;
    logic                 halt_sync;

    always_ff @(posedge sys_clk or negedge pll_lock) begin
        if (!pll_lock) begin
            a_sync    <= '0;
            d_sync    <= '0;
            rw_sync   <= 1'b1;
            phi2_sync <= 1'b0;
            halt_sync <= 1'b1;
        end else begin
            a_sync    <= a;
            d_sync    <= d_in;
            rw_sync   <= rw;
            phi2_sync <= phi2;
            halt_sync <= halt;
        end
    end

    // ======================================================================
    // Address decode
    // ======================================================================
    logic                in_cart;
    logic                in_status;
    logic                in_crc;
    logic                drive_next;
    cart_pkg::read_src_e src_next;

    assign in_cart   = (a_sync >= `CART_BASE);          // $4000-$FFFF
    assign in_status = (a_sync == `STATUS_ADDR);
    assign in_crc    = (a_sync >= `CRC_WIN_BASE) && (a_sync <= `CRC_WIN_LAST);

    always_comb begin
        if (game_mode) begin
            src_next = in_cart ? cart_pkg::SRC_CART : cart_pkg::SRC_NONE;
        end else if (in_status) begin
            src_next = cart_pkg::SRC_STATUS;
        end else if (in_crc) begin
            src_next = cart_pkg::SRC_CRC;
        end else if (in_cart) begin
            src_next = cart_pkg::SRC_BLANK;  // Menu mode, no ROM image
        end else begin
            src_next = cart_pkg::SRC_NONE;
        end
    end

    // CPU phase with halt high, or DMA while halt is low
    assign drive_next = (src_next != cart_pkg::SRC_NONE) && rw_sync &&
                        ((phi2_sync && halt_sync) || !halt_sync);

    // Write data is only valid in the high phase of phi2
    assign ctrl_write    = in_status && !rw_sync && phi2_sync;
    assign ctrl_data     = d_sync;
    assign cart_rd_index = a_sync - `CART_BASE;

    always_ff @(posedge sys_clk or negedge pll_lock) begin
        if (!pll_lock) begin
            read_src <= cart_pkg::SRC_NONE;
            crc_pos  <= '0;
            d_drive  <= 1'b0;
            buf_dir  <= 1'b1;
            buf_oe   <= 1'b1;   // Active low
        end else begin
            read_src <= src_next;
            crc_pos  <= a_sync[3:0];
            d_drive  <= drive_next;
            buf_dir  <= rw_sync;  // High points the buffer toward the CPU
            buf_oe   <= !(drive_next || ctrl_write);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cart_macros.svh ====
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

// ==========================================================================
// Bus map
// ==========================================================================
`define CART_BASE      16'h4000  // First cartridge byte
`define STATUS_ADDR    16'h0458  // Control write and status read
`define CRC_WIN_BASE   16'h7F00  // Menu text window
`define CRC_WIN_LAST   16'h7F0F

// ==========================================================================
// Image layout
// ==========================================================================
`define CART_BYTES     16'd49152 // On-chip cartridge capacity
`define SECTOR_BYTES   10'd512
`define HEADER_BYTES   10'd128   // Skipped at the start of sector 0
`define IMAGE_SECTORS  7'd97

// Status and filler bytes
`define STATUS_BUSY    8'h00
`define STATUS_READY   8'h80
`define BLANK_BYTE     8'hFF

`endif

// ==== verilog/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

    typedef logic [15:0] bus_addr_t;   // CPU address bus
    typedef logic [7:0]  data_byte_t;
    typedef logic [15:0] cart_index_t; // Offset into cartridge memory
    typedef logic [6:0]  sector_t;
    typedef logic [9:0]  byte_count_t; // Byte position inside a sector
    typedef logic [31:0] checksum_t;

    // Where a bus read gets its byte
    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_STATUS,
        SRC_CRC,
        SRC_CART,
        SRC_BLANK
    } read_src_e;

    // Sector loader FSM
    typedef enum logic [2:0] {
        LD_IDLE,
        LD_REQUEST,
        LD_RECEIVE,
        LD_NEXT,
        LD_COMPLETE
    } loader_state_e;

endpackage

`default_nettype wire

// ==== verilog/cart_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cart_macros.svh"

module cart_ram (
    input  wire                   sys_clk,
    input  wire                   wr_en,
    input  cart_pkg::cart_index_t wr_index,
    input  cart_pkg::data_byte_t  wr_data,
    input  cart_pkg::cart_index_t rd_index,
    output cart_pkg::data_byte_t  rd_data
);

    // Payload storage, infers block RAM
    cart_pkg::data_byte_t mem [0:`CART_BYTES-1];

    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    // Read every cycle, one cycle of latency
    always_ff @(posedge sys_clk) begin
        rd_data <= mem[rd_index];
    end

endmodule

`default_nettype wire

// ==== verilog/cart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cart_top (
    input  wire                  sys_clk,
    input  wire                  pll_lock,
    // CPU bus
    input  cart_pkg::bus_addr_t  a,
    input  wire                  rw,
    input  wire                  phi2,
    input  wire                  halt,
    input  cart_pkg::data_byte_t d_in,
    output cart_pkg::data_byte_t d_out,
    output wire                  d_drive,  // Board wrapper enables the pad driver
    output wire                  buf_dir,
    output wire                  buf_oe,
    // Sector source
    input  wire                  sd_ready,
    output wire                  sd_rd,
    output cart_pkg::sector_t    sd_sector,
    input  cart_pkg::data_byte_t sd_byte,
    input  wire                  sd_byte_valid
);

    // ======================================================================
    // Internal nets
    // ======================================================================
    cart_pkg::read_src_e   read_src;
    logic [3:0]            crc_pos;
    cart_pkg::cart_index_t cart_rd_index;
    cart_pkg::data_byte_t  ctrl_data;
    cart_pkg::data_byte_t  cart_data;
    cart_pkg::cart_index_t wr_index;
    cart_pkg::data_byte_t  wr_data;
    cart_pkg::checksum_t   checksum;
    logic                  ctrl_write;
    logic                  game_mode;
    logic                  busy;
    logic                  wr_en;

    // Decode stage
    bus_decode u_decode (
        .sys_clk       (sys_clk),
        .pll_lock      (pll_lock),
        .a             (a),
        .rw            (rw),
        .phi2          (phi2),
        .halt          (halt),
        .d_in          (d_in),
        .game_mode     (game_mode),
        .read_src      (read_src),
        .crc_pos       (crc_pos),
        .cart_rd_index (cart_rd_index),
        .ctrl_write    (ctrl_write),
        .ctrl_data     (ctrl_data),
        .d_drive       (d_drive),
        .buf_dir       (buf_dir),
        .buf_oe        (buf_oe)
    );

    // Execute stage
    image_loader u_loader (
        .sys_clk       (sys_clk),
        .pll_lock      (pll_lock),
        .sd_ready      (sd_ready),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .ctrl_write    (ctrl_write),
        .ctrl_data     (ctrl_data),
        .sd_rd         (sd_rd),
        .sd_sector     (sd_sector),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_data       (wr_data),
        .busy          (busy),
        .game_mode     (game_mode),
        .checksum      (checksum)
    );

    cart_ram u_ram (
        .sys_clk  (sys_clk),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .rd_index (cart_rd_index),
        .rd_data  (cart_data)
    );

    // Result stage
    read_mux u_mux (
        .sys_clk   (sys_clk),
        .pll_lock  (pll_lock),
        .read_src  (read_src),
        .crc_pos   (crc_pos),
        .busy      (busy),
        .checksum  (checksum),
        .cart_data (cart_data),
        .d_out     (d_out)
    );

endmodule

`default_nettype wire

// ==== verilog/image_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cart_macros.svh"

module image_loader (
    input  wire                   sys_clk,
    input  wire                   pll_lock,
    input  wire                   sd_ready,
    input  cart_pkg::data_byte_t  sd_byte,
    input  wire                   sd_byte_valid,
    input  wire                   ctrl_write,
    input  cart_pkg::data_byte_t  ctrl_data,
    output logic                  sd_rd,
    output cart_pkg::sector_t     sd_sector,
    output logic                  wr_en,
    output cart_pkg::cart_index_t wr_index,
    output cart_pkg::data_byte_t  wr_data,
    output logic                  busy,
    output logic                  game_mode,
    output cart_pkg::checksum_t   checksum
);

    cart_pkg::loader_state_e state;
    cart_pkg::byte_count_t   byte_count;
    cart_pkg::cart_index_t   load_index;  // Next free memory slot

    logic in_header;
    logic has_room;
    logic last_byte;
    logic last_sector;

    assign in_header   = (sd_sector == 7'd0) && (byte_count < `HEADER_BYTES);
    assign has_room    = (load_index < `CART_BYTES);   // Overflow is dropped
    assign last_byte   = (byte_count == `SECTOR_BYTES - 10'd1);
    assign last_sector = (sd_sector == `IMAGE_SECTORS - 7'd1);

    // ======================================================================
    // Loader FSM
    // ======================================================================
    always_ff @(posedge sys_clk or negedge pll_lock) begin
        if (!pll_lock) begin
            state      <= cart_pkg::LD_IDLE;
            sd_rd      <= 1'b0;
            sd_sector  <= '0;
            byte_count <= '0;
            load_index <= '0;
            wr_en      <= 1'b0;
            wr_index   <= '0;
            wr_data    <= '0;
            busy       <= 1'b1;  // Initial load pending
            game_mode  <= 1'b0;
            checksum   <= '0;
        end else begin
            sd_rd <= 1'b0;
            wr_en <= 1'b0;

            case (state)
                cart_pkg::LD_IDLE: begin
                    if (sd_ready) begin
                        state <= cart_pkg::LD_REQUEST;
                    end
                end

                cart_pkg::LD_REQUEST: begin
                    sd_rd      <= 1'b1;  // One cycle, sd_sector already valid
                    byte_count <= '0;
                    state      <= cart_pkg::LD_RECEIVE;
                end

                cart_pkg::LD_RECEIVE: begin
                    if (sd_byte_valid) begin
                        byte_count <= byte_count + 10'd1;
                        if (!in_header && has_room) begin
                            wr_en      <= 1'b1;
                            wr_index   <= load_index;
                            wr_data    <= sd_byte;
                            load_index <= load_index + 16'd1;
                            checksum   <= checksum + {24'd0, sd_byte};
                        end
                        if (last_byte) begin
                            state <= cart_pkg::LD_NEXT;
                        end
                    end
                end

                cart_pkg::LD_NEXT: begin
                    if (last_sector) begin
                        busy  <= 1'b0;
                        state <= cart_pkg::LD_COMPLETE;
                    end else begin
                        sd_sector <= sd_sector + 7'd1;
                        state     <= cart_pkg::LD_REQUEST;
                    end
                end

                cart_pkg::LD_COMPLETE: begin
                    // Menu commands, ignored once the game runs
                    if (ctrl_write && !game_mode) begin
                        if (ctrl_data[7]) begin
                            game_mode <= 1'b1;
                        end else if (ctrl_data[6]) begin
                            checksum   <= '0;
                            load_index <= '0;
                            sd_sector  <= '0;
                            busy       <= 1'b1;
                            state      <= cart_pkg::LD_REQUEST;
                        end
                    end
                end

                default: begin
                    state <= cart_pkg::LD_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/read_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cart_macros.svh"

module read_mux (
    input  wire                  sys_clk,
    input  wire                  pll_lock,
    input  cart_pkg::read_src_e  read_src,
    input  wire [3:0]            crc_pos,
    input  wire                  busy,
    input  cart_pkg::checksum_t  checksum,
    input  cart_pkg::data_byte_t cart_data,
    output cart_pkg::data_byte_t d_out
);

    // Nibble to upper case hex ASCII
    function automatic cart_pkg::data_byte_t hex_ascii(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'd0, nib};
        end
        return 8'h37 + {4'd0, nib};
    endfunction

    // Positions 5..12 map to checksum nibbles 7..0
    logic [2:0]           digit_idx;
    logic [3:0]           digit_nib;
    cart_pkg::data_byte_t crc_char;
    cart_pkg::data_byte_t sel_byte;

    assign digit_idx = 3'(4'd12 - crc_pos);
    assign digit_nib = checksum[{digit_idx, 2'b00} +: 4];

    // Text line "CRC: XXXXXXXX   "
    always_comb begin
        case (crc_pos)
            4'h0:    crc_char = 8'h43;  // C
            4'h1:    crc_char = 8'h52;  // R
            4'h2:    crc_char = 8'h43;  // C
            4'h3:    crc_char = 8'h3A;  // Colon
            4'h4:    crc_char = 8'h20;
            4'hD, 4'hE, 4'hF: crc_char = 8'h20;
            default: crc_char = hex_ascii(digit_nib);
        endcase
    end

    always_comb begin
        case (read_src)
            cart_pkg::SRC_STATUS: sel_byte = busy ? `STATUS_BUSY : `STATUS_READY;
            cart_pkg::SRC_CRC:    sel_byte = crc_char;
            cart_pkg::SRC_CART:   sel_byte = cart_data;
            default:              sel_byte = `BLANK_BYTE;
        endcase
    end

    always_ff @(posedge sys_clk or negedge pll_lock) begin
        if (!pll_lock) begin
            d_out <= `BLANK_BYTE;
        end else begin
            d_out <= sel_byte;
        end
    end

endmodule

`default_nettype wire
